/* src/kyber_consts.svh */
`ifndef KYBER_CONSTS_SVH
`define KYBER_CONSTS_SVH

// modulus and K2RED factor, q = 13 * 2^8 + 1
`define KYBER_Q     3329
`define K2RED_K     13

// datapath widths
`define COEF_W      12
`define PROD_W      24
`define CNT_W       9

// result buffer depth, also the credit limit
`define FIFO_DEPTH  8

// 1 multiply cycle + 4 reduce cycles
`define PIPE_LAT    5

`endif

/* src/kyber_pkg.sv */
`include "kyber_consts.svh"

package kyber_pkg;

    typedef logic [`COEF_W-1:0] coef_t;

    // block length, up to 256
    typedef logic [`CNT_W-1:0] count_t;

    // product split at bit 8 for the K2RED fold
    typedef struct packed {
        logic [`PROD_W-9:0] hi;
        logic [7:0]         lo;
    } prod_split_t;

    typedef union packed {
        logic [`PROD_W-1:0] raw;
        prod_split_t        split;
    } prod_u;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DRAIN
    } ctrl_state_e;

endpackage

/* src/coef_mult.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module coef_mult (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  kyber_pkg::coef_t a,
    input  kyber_pkg::coef_t b,
    output logic             prod_valid,
    output kyber_pkg::prod_u prod
);

    // full-width product, operands zero-extended first
    logic [`PROD_W-1:0] mult;

    assign mult = `PROD_W'(a) * `PROD_W'(b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    // product only loads on an accepted pair
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod.raw <= mult;
        end
    end

endmodule

/* src/k2red.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module k2red (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             c_valid,
    input  kyber_pkg::prod_u c,
    output logic             r_valid,
    output kyber_pkg::coef_t r
);

    // split point, q = K * 2^LO_W + 1
    localparam int LO_W = $clog2(`KYBER_Q / `K2RED_K);
    localparam int HI_W = `PROD_W - LO_W;
    // first sum spans -(2^HI_W - 1) .. 13*255
    localparam int S1_W = HI_W + 2;
    // signed high part of the first sum
    localparam int H2_W = S1_W - LO_W;
    // second sum stays within a few hundred of 0..q
    localparam int S2_W = `COEF_W + 2;

    logic [3:0] vld_q;

    // stage 1, first split with pre-shifted lo
    logic [HI_W-1:0] s1_hi;
    logic [LO_W-1:0] s1_lo;
    logic [LO_W+2:0] s1_lo_x8;
    logic [LO_W+1:0] s1_lo_x4;

    // stage 2
    logic [S1_W-1:0] sum1_d;
    logic [S1_W-1:0] s2_sum;

    // stage 3, second split
    logic [H2_W-1:0] s3_hi;
    logic [LO_W-1:0] s3_lo;
    logic [LO_W+2:0] s3_lo_x8;
    logic [LO_W+1:0] s3_lo_x4;

    // stage 4
    logic [S2_W-1:0] sum2_d;
    logic [S2_W-1:0] corr_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2:0], c_valid};
        end
    end

    assign r_valid = vld_q[3];

    //////////////////////////////////////////////////////////////////////
    // pass one, 13*lo - hi
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        s1_hi    <= c.split.hi;
        s1_lo    <= c.split.lo;
        s1_lo_x8 <= {c.split.lo, 3'b000};
        s1_lo_x4 <= {c.split.lo, 2'b00};
    end

    // two's complement in S1_W bits, may go negative
    assign sum1_d = S1_W'(s1_lo_x8) + S1_W'(s1_lo_x4) + S1_W'(s1_lo) - S1_W'(s1_hi);

    always_ff @(posedge clk) begin
        s2_sum <= sum1_d;
    end

    //////////////////////////////////////////////////////////////////////
    // pass two, same fold on the signed intermediate
    //////////////////////////////////////////////////////////////////////

    // upper bits act as an arithmetic shift right by LO_W
    always_ff @(posedge clk) begin
        s3_hi    <= s2_sum[S1_W-1:LO_W];
        s3_lo    <= s2_sum[LO_W-1:0];
        s3_lo_x8 <= {s2_sum[LO_W-1:0], 3'b000};
        s3_lo_x4 <= {s2_sum[LO_W-1:0], 2'b00};
    end

    assign sum2_d = S2_W'(s3_lo_x8) + S2_W'(s3_lo_x4) + S2_W'(s3_lo)
                  - {{(S2_W-H2_W){s3_hi[H2_W-1]}}, s3_hi};

    // one correction step brings it into 0..q-1
    always_comb begin
        if (sum2_d[S2_W-1]) begin
            corr_d = sum2_d + S2_W'(`KYBER_Q);
        end else if (sum2_d >= S2_W'(`KYBER_Q)) begin
            corr_d = sum2_d - S2_W'(`KYBER_Q);
        end else begin
            corr_d = sum2_d;
        end
    end

    always_ff @(posedge clk) begin
        r <= corr_d[`COEF_W-1:0];
    end

endmodule

/* src/result_fifo.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module result_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_valid,
    input  kyber_pkg::coef_t       wr_data,
    input  logic                   rd_ready,
    output logic                   rd_valid,
    output kyber_pkg::coef_t       rd_data,
    output logic [$clog2(DEPTH):0] level
);

    import kyber_pkg::*;

    localparam int AW = $clog2(DEPTH);

    coef_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          rd_fire;

    assign rd_valid = (level != '0);
    assign rd_fire  = rd_valid && rd_ready;

    // head entry shows before it is read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap naturally, DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_valid, rd_fire})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* src/coef_counter.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module coef_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_len,
    input  kyber_pkg::count_t            block_len,
    input  logic                         accept,
    input  logic                         accept_en,
    input  logic                         red_valid,
    input  logic                         emit,
    input  logic [$clog2(`FIFO_DEPTH):0] fifo_level,
    output logic                         in_ready,
    output logic                         last_in,
    output logic                         last_out
);

    import kyber_pkg::*;

    localparam int LVL_W = $clog2(`FIFO_DEPTH) + 1;
    localparam int FL_W  = $clog2(`PIPE_LAT + 1);
    localparam int SUM_W = LVL_W + 1;

    count_t           len_q;
    count_t           acc_cnt;
    count_t           emit_cnt;
    logic [FL_W-1:0]  flight_cnt;
    logic [SUM_W-1:0] credit_sum;
    logic             credit_ok;

    // items in the pipe plus items buffered must fit the FIFO
    assign credit_sum = SUM_W'(flight_cnt) + SUM_W'(fifo_level);
    assign credit_ok  = (credit_sum < SUM_W'(`FIFO_DEPTH));
    assign in_ready   = accept_en && credit_ok;

    // last_in is qualified by accept in the controller
    assign last_in  = (acc_cnt == len_q - 1'b1);
    assign last_out = emit && (emit_cnt == len_q - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            len_q      <= '0;
            acc_cnt    <= '0;
            emit_cnt   <= '0;
            flight_cnt <= '0;
        end else begin
            if (load_len) begin
                len_q    <= block_len;
                acc_cnt  <= '0;
                emit_cnt <= '0;
            end else begin
                if (accept) begin
                    acc_cnt <= acc_cnt + 1'b1;
                end
                if (emit) begin
                    emit_cnt <= emit_cnt + 1'b1;
                end
            end
            case ({accept, red_valid})
                2'b10: flight_cnt <= flight_cnt + 1'b1;
                2'b01: flight_cnt <= flight_cnt - 1'b1;
                default: flight_cnt <= flight_cnt;
            endcase
        end
    end

endmodule

/* src/poly_ctrl.sv */
`timescale 1ns/1ps

module poly_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic accept,
    input  logic last_in,
    input  logic last_out,
    output logic accept_en,
    output logic load_len,
    output logic busy,
    output logic done
);

    import kyber_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // start only counts while idle
    assign load_len  = (state_q == ST_IDLE) && start;
    assign accept_en = (state_q == ST_BUSY);
    assign busy      = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (accept && last_in) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (last_out) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // done lands in the first idle cycle after the last result leaves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            done    <= 1'b0;
        end else begin
            state_q <= state_d;
            done    <= (state_q == ST_DRAIN) && last_out;
        end
    end

endmodule

/* src/pointwise_mul.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module pointwise_mul (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  kyber_pkg::count_t block_len,
    output logic              busy,
    input  logic              in_valid,
    output logic              in_ready,
    input  kyber_pkg::coef_t  in_a,
    input  kyber_pkg::coef_t  in_b,
    output logic              out_valid,
    input  logic              out_ready,
    output kyber_pkg::coef_t  out_r,
    output logic              done
);

    import kyber_pkg::*;

    logic                         accept;
    logic                         emit;
    logic                         accept_en;
    logic                         load_len;
    logic                         last_in;
    logic                         last_out;
    logic                         prod_valid;
    prod_u                        prod;
    logic                         red_valid;
    coef_t                        red_r;
    logic [$clog2(`FIFO_DEPTH):0] fifo_level;

    // handshake strobes
    assign accept = in_valid && in_ready;
    assign emit   = out_valid && out_ready;

    //////////////////////////////////////////////////////////////////////
    // control and credit
    //////////////////////////////////////////////////////////////////////

    poly_ctrl poly_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .accept    (accept),
        .last_in   (last_in),
        .last_out  (last_out),
        .accept_en (accept_en),
        .load_len  (load_len),
        .busy      (busy),
        .done      (done)
    );

    coef_counter coef_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_len   (load_len),
        .block_len  (block_len),
        .accept     (accept),
        .accept_en  (accept_en),
        .red_valid  (red_valid),
        .emit       (emit),
        .fifo_level (fifo_level),
        .in_ready   (in_ready),
        .last_in    (last_in),
        .last_out   (last_out)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath, multiply -> reduce -> buffer
    //////////////////////////////////////////////////////////////////////

    coef_mult coef_mult_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (accept),
        .a          (in_a),
        .b          (in_b),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    k2red k2red_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .c_valid (prod_valid),
        .c       (prod),
        .r_valid (red_valid),
        .r       (red_r)
    );

    result_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) result_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (red_valid),
        .wr_data  (red_r),
        .rd_ready (out_ready),
        .rd_valid (out_valid),
        .rd_data  (out_r),
        .level    (fifo_level)
    );

endmodule

/* verification/pointwise_mul_tb.sv */
`timescale 1ns/1ps
`include "kyber_consts.svh"

module pointwise_mul_tb;

    import kyber_pkg::*;

    localparam int TIMEOUT = 2000;

    logic   clk;
    logic   rst_n;
    logic   start;
    count_t block_len;
    logic   busy;
    logic   in_valid;
    logic   in_ready;
    coef_t  in_a;
    coef_t  in_b;
    logic   out_valid;
    logic   out_ready;
    coef_t  out_r;
    logic   done;

    integer seed = 32'hb45f452d;
    integer rdy_seed = 32'hb45f452d;
    int     ready_pct;

    // monitor state, written only by the monitor process
    coef_t  exp_q[$];
    coef_t  exp_r;
    count_t cur_len;
    count_t acc_cnt;
    count_t res_cnt;
    int     block_dones;
    int     dones_total;
    int     pairs_taken;
    logic   stalled_seen;
    // last result of the block left on the previous edge
    logic   last_result_prev;

    coef_t  corner_tbl [3] = '{12'd0, 12'd1, 12'd3328};

    pointwise_mul pointwise_mul_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .block_len (block_len),
        .busy      (busy),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_r     (out_r),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference and checks
    //////////////////////////////////////////////////////////////////////

    // K2RED output is k^2 * a * b mod q
    function automatic coef_t ref_k2red(coef_t a, coef_t b);
        longint unsigned prod;
        prod = 64'(a) * 64'(b) * 64'(`K2RED_K * `K2RED_K);
        return coef_t'(prod % 64'(`KYBER_Q));
    endfunction

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_coef(coef_t got, coef_t exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s, got %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_count(count_t got, count_t exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s, got %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    // handshakes are sampled at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (start && !busy) begin
                cur_len      = block_len;
                acc_cnt      = '0;
                res_cnt      = '0;
                block_dones  = 0;
                stalled_seen = 1'b0;
            end
            if (busy && !in_ready && acc_cnt < cur_len) begin
                stalled_seen = 1'b1;
            end
            if (in_ready && acc_cnt == cur_len) begin
                stop_with_error("in_ready was high after the last pair of the block");
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_k2red(in_a, in_b));
                acc_cnt++;
                pairs_taken++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("a result arrived with no pair pending");
                end else begin
                    exp_r = exp_q.pop_front();
                    check_coef(out_r, exp_r, "result value");
                    res_cnt++;
                end
            end
            if (done) begin
                check_count(res_cnt, cur_len, "results before done");
                if (last_result_prev !== 1'b1) begin
                    stop_with_error("done did not come one cycle after the last result");
                end
                block_dones++;
                dones_total++;
            end
            last_result_prev = out_valid && out_ready && (res_cnt == cur_len);
        end
    end

    // output back-pressure with a random duty
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = rst_n && (({$random(rdy_seed)} % 100) < ready_pct);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_pair(coef_t a, coef_t b);
        int prev;
        int waited;
        prev     = pairs_taken;
        waited   = 0;
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error("a pair was never accepted by the DUT");
            end
        end while (pairs_taken == prev);
    endtask

    task automatic run_block(count_t len, int gap_max, bit corners, int stray_at);
        int    gap;
        int    waited;
        int    done_before;
        coef_t a;
        coef_t b;
        done_before = dones_total;
        @(negedge clk);
        start     = 1'b1;
        block_len = len;
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < int'(len); i++) begin
            gap = int'({$random(seed)} % (gap_max + 1));
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            // a second start mid-block must be ignored
            if (i == stray_at) begin
                in_valid  = 1'b0;
                start     = 1'b1;
                block_len = count_t'(5);
                @(negedge clk);
                start     = 1'b0;
                block_len = len;
            end
            if (corners && i < 9) begin
                a = corner_tbl[i / 3];
                b = corner_tbl[i % 3];
            end else begin
                a = coef_t'({$random(seed)} % `KYBER_Q);
                b = coef_t'({$random(seed)} % `KYBER_Q);
            end
            send_pair(a, b);
        end
        in_valid = 1'b0;
        waited   = 0;
        while (dones_total == done_before) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error("done never arrived");
            end
        end
        // look for a second done pulse
        repeat (6) @(negedge clk);
        check_count(count_t'(block_dones), count_t'(1), "done pulses in block");
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        block_len = '0;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        ready_pct = 70;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // idle after reset
        repeat (20) begin
            @(posedge clk);
            if (busy || done || in_ready || out_valid) begin
                stop_with_error("busy, done, in_ready or out_valid rose without a start");
            end
        end

        run_block(count_t'(1), 3, 1'b0, -1);
        ready_pct = 50;
        run_block(count_t'(7), 2, 1'b1, -1);
        ready_pct = 80;
        run_block(count_t'(256), 2, 1'b1, -1);

        // heavy back-pressure
        ready_pct = 10;
        run_block(count_t'(40), 0, 1'b0, -1);
        if (!stalled_seen) begin
            stop_with_error("in_ready never dropped while the output was stalled");
        end

        ready_pct = 60;
        run_block(count_t'(20), 1, 1'b0, 6);

        @(negedge clk);
        check_count(count_t'(dones_total), count_t'(5), "blocks completed");
        if (busy || in_ready || out_valid) begin
            stop_with_error("the DUT was not idle at the end of the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+src
src/kyber_pkg.sv
src/coef_mult.sv
src/k2red.sv
src/result_fifo.sv
src/coef_counter.sv
src/poly_ctrl.sv
src/pointwise_mul.sv
verification/pointwise_mul_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := pointwise_mul_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
COMMON     := --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON) -Mdir $(BUILD_DIR)
PASS_MSG   := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
